/* project.f */
rtl/clint_pkg.sv
rtl/apb_slave_bridge.sv
rtl/clint_regs.sv
rtl/clint_timer.sv
rtl/clint_top.sv
tb/clint_properties.sv
tb/clint_tb.sv

/* Makefile */
# Verilator build and run of the CLINT testbench

TOP = clint_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f project.f -Mdir obj_dir -o V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* tb/clint_tb.sv */
// CLINT testbench
// APB register tests plus mtime and mtip checks against a reference model

`default_nettype none

module clint_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import clint_pkg::*;

    localparam int unsigned CPU_TOTAL   = 4;
    localparam int          CLK_PERIOD  = 4;                  // ns
    localparam int          MAX_XFERS   = 2000;               // Generous bound on transfers
    localparam int          XFER_CYCLES = 5;
    localparam int          WATCHDOG_NS = MAX_XFERS * XFER_CYCLES * CLK_PERIOD;
    localparam int          N_BAD       = 10;
    localparam logic [15:0] BAD_ADDRS [N_BAD] = '{
        16'h0001, 16'h0002, 16'h3FFC, 16'h4003, 16'h4006,
        16'h7FF8, 16'h8000, 16'hBFF0, 16'hBFF9, 16'hFFFC
    };

    logic                  i_clk;
    logic                  i_nrst;
    apb_req_t              apb_req;
    apb_resp_t             apb_resp;
    logic [63:0]           mtimer;
    logic [CPU_TOTAL-1:0]  msip;
    logic [CPU_TOTAL-1:0]  mtip;

    // Model of the writable registers
    logic [CPU_TOTAL-1:0]  msip_model;
    logic [63:0]           cmp_model [CPU_TOTAL];

    clint_top #(
        .CPU_TOTAL (CPU_TOTAL)
    ) DUT (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_apb    (apb_req),
        .o_apb    (apb_resp),
        .o_mtimer (mtimer),
        .o_msip   (msip),
        .o_mtip   (mtip)
    );

    initial i_clk = 1'b0;
    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic stop_failed();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_resp(input string name, input apb_resp_t exp, input apb_resp_t act);
        if (act !== exp) begin
            $display("** Error: %s: expected prdata=%h pready=%b pslverr=%b",
                     name, exp.prdata, exp.pready, exp.pslverr,
                     ", actual prdata=%h pready=%b pslverr=%b",
                     act.prdata, act.pready, act.pslverr);
            stop_failed();
        end
    endtask

    task automatic check_mask(input string name, input logic [CPU_TOTAL-1:0] exp,
                              input logic [CPU_TOTAL-1:0] act);
        if (act !== exp) begin
            $display("** Error: %s: expected %b, actual %b", name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("** Error: %s: expected %h, actual %h", name, exp, act);
            stop_failed();
        end
    endtask

    function automatic logic [15:0] msip_addr(input int unsigned hart);
        return MSIP_BASE + 16'(4 * hart);
    endfunction

    function automatic logic [15:0] cmp_addr(input int unsigned hart, input logic hi);
        return MTIMECMP_BASE + 16'(8 * hart) + (hi ? 16'd4 : 16'd0);
    endfunction

    // Register class from the CLINT address map
    function automatic reg_kind_e addr_kind(input logic [15:0] addr);
        if (addr[1:0] != 2'b00) return REG_NONE;
        if (addr < MTIMECMP_BASE) begin
            return ((addr - MSIP_BASE) / 4 < CPU_TOTAL) ? REG_MSIP : REG_NONE;
        end
        if (addr < 16'h8000) begin
            if ((addr - MTIMECMP_BASE) / 8 >= CPU_TOTAL) return REG_NONE;
            return addr[2] ? REG_MTIMECMP_HI : REG_MTIMECMP_LO;
        end
        if (addr == MTIME_ADDR) return REG_MTIME_LO;
        if (addr == MTIME_ADDR + 16'd4) return REG_MTIME_HI;
        return REG_NONE;
    endfunction

    function automatic int unsigned hart_of(input logic [15:0] addr);
        if (addr < MTIMECMP_BASE) begin
            return (addr - MSIP_BASE) / 4;
        end
        return (addr - MTIMECMP_BASE) / 8;
    endfunction

    // Expected response; mt_setup is o_mtimer seen in the setup cycle
    function automatic apb_resp_t ref_read(input logic wr, input logic [15:0] addr,
                                           input logic [63:0] mt_setup);
        apb_resp_t   exp;
        reg_kind_e   kind;
        int unsigned hart;
        logic [63:0] mt_seen;
        kind        = addr_kind(addr);
        hart        = hart_of(addr);
        mt_seen     = mt_setup + 64'd1;        // Counter has moved on by the access cycle
        exp         = '0;
        exp.pready  = 1'b1;
        case (kind)
            REG_MSIP:        exp.prdata = {31'h0, msip_model[hart]};
            REG_MTIMECMP_LO: exp.prdata = cmp_model[hart][31:0];
            REG_MTIMECMP_HI: exp.prdata = cmp_model[hart][63:32];
            REG_MTIME_LO: begin
                exp.prdata  = mt_seen[31:0];
                exp.pslverr = wr;              // Read-only
            end
            REG_MTIME_HI: begin
                exp.prdata  = mt_seen[63:32];
                exp.pslverr = wr;
            end
            default:         exp.pslverr = 1'b1;
        endcase
        if (wr) exp.prdata = 32'h0;
        return exp;
    endfunction

    task automatic model_write(input logic [15:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        reg_kind_e   kind;
        int unsigned hart;
        int unsigned base;
        kind = addr_kind(addr);
        hart = hart_of(addr);
        base = (kind == REG_MTIMECMP_HI) ? 32 : 0;
        if (kind == REG_MSIP && strb[0]) begin
            msip_model[hart] = data[0];
        end else if (kind == REG_MTIMECMP_LO || kind == REG_MTIMECMP_HI) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) cmp_model[hart][base + 8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    // One APB transfer: setup, access with checks, then idle
    task automatic apb_xfer(input string name, input logic wr, input logic [15:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
        apb_resp_t   exp;
        logic [63:0] mt_setup;
        @(negedge i_clk);
        apb_req.paddr   = addr;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.pwdata  = data;
        apb_req.pstrb   = strb;
        mt_setup        = mtimer;
        exp             = ref_read(wr, addr, mt_setup);
        @(negedge i_clk);
        apb_req.penable = 1'b1;
        if (wr) model_write(addr, data, strb);
        #1;
        if (apb_resp.pready !== 1'b1) begin
            $display("%s: pready was not high in the first access cycle", name);
            stop_failed();
        end
        check_resp(name, exp, apb_resp);
        check_mask({name, " msip"}, msip_model, msip);
        @(negedge i_clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input string name, input logic [15:0] addr,
                             input logic [31:0] data, input logic [3:0] strb);
        apb_xfer(name, 1'b1, addr, data, strb);
    endtask

    task automatic apb_read(input string name, input logic [15:0] addr);
        apb_xfer(name, 1'b0, addr, 32'h0, 4'h0);
    endtask

    task automatic read_all_regs(input string name);
        for (int h = 0; h < CPU_TOTAL; h++) begin
            apb_read({name, " msip"}, msip_addr(h));
            apb_read({name, " mtimecmp lo"}, cmp_addr(h, 1'b0));
            apb_read({name, " mtimecmp hi"}, cmp_addr(h, 1'b1));
        end
    endtask

    // Every cycle mtip must follow last cycle's compare
    initial begin : mtip_monitor
        logic [CPU_TOTAL-1:0] expected;
        logic                 primed;
        primed   = 1'b0;
        expected = '0;
        forever begin
            @(negedge i_clk);
            #1;
            if (!i_nrst) begin
                primed = 1'b0;
            end else begin
                if (primed) check_mask("mtip monitor", expected, mtip);
                for (int i = 0; i < CPU_TOTAL; i++) begin
                    expected[i] = (mtimer >= cmp_model[i]);
                end
                primed = 1'b1;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        stop_failed();
    end

    initial begin : main
        logic [63:0] base;
        logic [63:0] target;
        void'($urandom(62066));
        apb_req    = '0;
        i_nrst     = 1'b0;
        msip_model = '0;
        for (int h = 0; h < CPU_TOTAL; h++) cmp_model[h] = 64'h0;
        repeat (8) @(negedge i_clk);
        i_nrst = 1'b1;

        check_mask("reset msip", '0, msip);
        read_all_regs("reset");

        repeat (40) begin
            apb_write("msip write", msip_addr($urandom_range(0, CPU_TOTAL - 1)),
                      $urandom, 4'($urandom_range(0, 15)));
        end
        read_all_regs("msip readback");

        repeat (60) begin
            apb_write("mtimecmp write",
                      cmp_addr($urandom_range(0, CPU_TOTAL - 1), 1'($urandom_range(0, 1))),
                      $urandom, 4'($urandom_range(0, 15)));
        end
        read_all_regs("mtimecmp readback");

        repeat (8) begin
            apb_read("mtime lo read", MTIME_ADDR);
            apb_read("mtime hi read", MTIME_ADDR + 16'd4);
        end
        apb_write("mtime write", MTIME_ADDR, $urandom, 4'hF);
        @(negedge i_clk);
        base = mtimer;
        repeat (10) @(negedge i_clk);
        check_word("mtime counting", base + 64'd10, mtimer);

        // Park every compare far ahead, then arm each one close by
        for (int h = 0; h < CPU_TOTAL; h++) begin
            apb_write("mtimecmp park", cmp_addr(h, 1'b1), 32'hFFFF_FFFF, 4'hF);
        end
        for (int h = 0; h < CPU_TOTAL; h++) begin
            target = mtimer + 64'($urandom_range(20, 200));
            apb_write("mtimecmp arm lo", cmp_addr(h, 1'b0), target[31:0], 4'hF);
            apb_write("mtimecmp arm hi", cmp_addr(h, 1'b1), target[63:32], 4'hF);
        end
        wait (mtip == '1);

        for (int h = CPU_TOTAL; h < 16; h++) begin
            apb_write("bad hart msip write", msip_addr(h), $urandom, 4'hF);
            apb_read("bad hart msip read", msip_addr(h));
            apb_write("bad hart mtimecmp write", cmp_addr(h, 1'b0), $urandom, 4'hF);
            apb_read("bad hart mtimecmp read", cmp_addr(h, 1'b1));
        end
        for (int i = 0; i < N_BAD; i++) begin
            apb_write("bad address write", BAD_ADDRS[i], $urandom, 4'hF);
            apb_read("bad address read", BAD_ADDRS[i]);
        end
        read_all_regs("error readback");

        repeat (4) @(negedge i_clk);
        if (DUT.u_props.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_failed();
        end
    end

endmodule

`default_nettype wire

/* tb/clint_properties.sv */
// CLINT assertions
// APB response rules, reset state and the mtime count, bound to clint_top

`default_nettype none

module clint_properties #(
    parameter int unsigned CPU_TOTAL = 4
) (
    input logic                  i_clk,
    input logic                  i_nrst,
    input clint_pkg::apb_req_t   i_apb_req,
    input clint_pkg::apb_resp_t  i_apb_resp,
    input logic [63:0]           i_mtimer,
    input logic [CPU_TOTAL-1:0]  i_msip,
    input logic [CPU_TOTAL-1:0]  i_mtip
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;    // Failed assertions so far

    // pready only answers an access phase
    a_pready_access: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_apb_resp.pready |-> (i_apb_req.psel && i_apb_req.penable)
    ) else begin
        $error("pready high without psel and penable");
        fail_count++;
    end

    a_pslverr_ready: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_apb_resp.pslverr |-> i_apb_resp.pready
    ) else begin
        $error("pslverr high without pready");
        fail_count++;
    end

    // Interrupt lines are clear as reset is let go
    a_reset_clear: assert property (@(posedge i_clk)
        $rose(i_nrst) |-> (i_msip == '0 && i_mtip == '0)
    ) else begin
        $error("msip or mtip set right after reset");
        fail_count++;
    end

    a_mtime_step: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $past(i_nrst) |-> (i_mtimer == $past(i_mtimer) + 64'd1)
    ) else begin
        $error("mtime did not advance by one");
        fail_count++;
    end

endmodule

bind clint_top clint_properties #(
    .CPU_TOTAL (CPU_TOTAL)
) u_props (
    .i_clk      (i_clk),
    .i_nrst     (i_nrst),
    .i_apb_req  (i_apb),
    .i_apb_resp (o_apb),
    .i_mtimer   (o_mtimer),
    .i_msip     (o_msip),
    .i_mtip     (o_mtip)
);

`default_nettype wire

/* rtl/clint_top.sv */
// CLINT top level
// APB bridge, register file and machine timer

`default_nettype none

module clint_top #(
    parameter int unsigned CPU_TOTAL = 4      // Number of harts, 1 to 16
) (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  clint_pkg::apb_req_t   i_apb,
    output clint_pkg::apb_resp_t  o_apb,
    output logic [63:0]           o_mtimer,   // Shared mtime copy for the harts
    output logic [CPU_TOTAL-1:0]  o_msip,     // Software interrupt pending
    output logic [CPU_TOTAL-1:0]  o_mtip      // Timer interrupt pending
);

    import clint_pkg::*;

    reg_req_t                    reg_req;
    reg_resp_t                   reg_resp;
    logic [63:0]                 mtime;
    logic [CPU_TOTAL-1:0][63:0]  mtimecmp;

    apb_slave_bridge u_bridge (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_apb  (i_apb),
        .o_apb  (o_apb),
        .o_req  (reg_req),
        .i_resp (reg_resp)
    );

    clint_regs #(
        .CPU_TOTAL (CPU_TOTAL)
    ) u_regs (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_req      (reg_req),
        .o_resp     (reg_resp),
        .i_mtime    (mtime),
        .o_msip     (o_msip),
        .o_mtimecmp (mtimecmp)
    );

    clint_timer #(
        .CPU_TOTAL (CPU_TOTAL)
    ) u_timer (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_mtimecmp (mtimecmp),
        .o_mtime    (mtime),
        .o_mtip     (o_mtip)
    );

    assign o_mtimer = mtime;

endmodule

`default_nettype wire

/* rtl/clint_timer.sv */
// CLINT machine timer
// Free-running 64-bit mtime and one registered compare per hart for mtip

`default_nettype none

module clint_timer #(
    parameter int unsigned CPU_TOTAL = 4
) (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic [CPU_TOTAL-1:0][63:0]  i_mtimecmp,
    output logic [63:0]                 o_mtime,
    output logic [CPU_TOTAL-1:0]        o_mtip
);

    logic [63:0]          mtime_q;
    logic [CPU_TOTAL-1:0] mtip_q;

    // Counts every clock once out of reset
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            mtime_q <= 64'h0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // Pending when mtime has reached the hart's compare value.
    // Both start at zero, so every mtip rises one cycle after reset.
    for (genvar i = 0; i < CPU_TOTAL; i++) begin : g_hart
        always_ff @(posedge i_clk or negedge i_nrst) begin
            if (!i_nrst) begin
                mtip_q[i] <= 1'b0;
            end else begin
                mtip_q[i] <= (mtime_q >= i_mtimecmp[i]);
            end
        end
    end

    assign o_mtime = mtime_q;
    assign o_mtip  = mtip_q;

endmodule

`default_nettype wire

/* rtl/clint_regs.sv */
// CLINT register file
// Address decode, msip bits, mtimecmp registers and registered read response

`default_nettype none

module clint_regs #(
    parameter int unsigned CPU_TOTAL = 4
) (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  clint_pkg::reg_req_t         i_req,
    output clint_pkg::reg_resp_t        o_resp,
    input  logic [63:0]                 i_mtime,
    output logic [CPU_TOTAL-1:0]        o_msip,
    output logic [CPU_TOTAL-1:0][63:0]  o_mtimecmp
);

    import clint_pkg::*;

    localparam int HART_W = (CPU_TOTAL > 1) ? $clog2(CPU_TOTAL) : 1;

    logic [CPU_TOTAL-1:0]        msip_q;
    logic [CPU_TOTAL-1:0][63:0]  mtimecmp_q;
    reg_resp_t                   resp_q;

    reg_kind_e                   kind;
    logic [HART_W-1:0]           hart;
    logic [11:0]                 msip_idx;     // 4-byte stride
    logic [10:0]                 cmp_idx;      // 8-byte stride
    logic [31:0]                 cmp_word;     // Addressed mtimecmp half
    logic [31:0]                 cmp_merged;   // After byte strobes
    logic [63:0]                 mtime_next;   // mtime as seen in the access cycle
    logic [31:0]                 rdata;
    logic                        err;

    assign msip_idx   = i_req.addr[13:2];
    assign cmp_idx    = i_req.addr[13:3];
    assign mtime_next = i_mtime + 64'd1;

    // Address decode
    always_comb begin
        kind = REG_NONE;
        hart = '0;
        if (i_req.addr[1:0] == 2'b00) begin
            if (i_req.addr[15:14] == MSIP_BASE[15:14]) begin
                if (msip_idx < CPU_TOTAL) begin
                    kind = REG_MSIP;
                    hart = msip_idx[HART_W-1:0];
                end
            end else if (i_req.addr[15:14] == MTIMECMP_BASE[15:14]) begin
                if (cmp_idx < CPU_TOTAL) begin
                    kind = i_req.addr[2] ? REG_MTIMECMP_HI : REG_MTIMECMP_LO;
                    hart = cmp_idx[HART_W-1:0];
                end
            end else if (i_req.addr == MTIME_ADDR) begin
                kind = REG_MTIME_LO;
            end else if (i_req.addr == MTIME_ADDR + 16'd4) begin
                kind = REG_MTIME_HI;
            end
        end
    end

    // Byte-strobe merge into the selected mtimecmp word
    always_comb begin
        cmp_word = (kind == REG_MTIMECMP_HI) ? mtimecmp_q[hart][63:32]
                                             : mtimecmp_q[hart][31:0];
        cmp_merged = cmp_word;
        for (int b = 0; b < 4; b++) begin
            if (i_req.wstrb[b]) begin
                cmp_merged[8*b +: 8] = i_req.wdata[8*b +: 8];
            end
        end
    end

    // Read data and error
    always_comb begin
        rdata = 32'h0;
        err   = 1'b0;
        case (kind)
            REG_MSIP:        rdata = {31'h0, msip_q[hart]};
            REG_MTIMECMP_LO: rdata = mtimecmp_q[hart][31:0];
            REG_MTIMECMP_HI: rdata = mtimecmp_q[hart][63:32];
            REG_MTIME_LO: begin
                rdata = mtime_next[31:0];
                err   = i_req.write;               // mtime is read-only
            end
            REG_MTIME_HI: begin
                rdata = mtime_next[63:32];
                err   = i_req.write;
            end
            default:         err = 1'b1;           // Unmapped, misaligned or bad hart
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            msip_q     <= '0;
            mtimecmp_q <= '0;
            resp_q     <= '0;
        end else if (i_req.valid) begin
            resp_q.rdata <= i_req.write ? 32'h0 : rdata;
            resp_q.err   <= err;
            if (i_req.write) begin
                case (kind)
                    REG_MSIP: begin
                        if (i_req.wstrb[0]) begin
                            msip_q[hart] <= i_req.wdata[0];
                        end
                    end
                    REG_MTIMECMP_LO: mtimecmp_q[hart][31:0]  <= cmp_merged;
                    REG_MTIMECMP_HI: mtimecmp_q[hart][63:32] <= cmp_merged;
                    default: begin
                    end
                endcase
            end
        end
    end

    assign o_resp     = resp_q;
    assign o_msip     = msip_q;
    assign o_mtimecmp = mtimecmp_q;

endmodule

`default_nettype wire

/* rtl/apb_slave_bridge.sv */
// APB slave bridge
// Turns each APB transfer into one internal register request, zero wait states

`default_nettype none

module apb_slave_bridge (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  clint_pkg::apb_req_t   i_apb,   // From APB master
    output clint_pkg::apb_resp_t  o_apb,   // To APB master
    output clint_pkg::reg_req_t   o_req,   // To register file
    input  clint_pkg::reg_resp_t  i_resp   // Registered response from register file
);

    import clint_pkg::*;

    apb_phase_e phase_q;
    apb_phase_e phase_d;
    logic       setup;                     // psel high, penable low
    logic       access;                    // Access phase of an accepted transfer

    assign setup  = i_apb.psel && !i_apb.penable;
    assign access = (phase_q == PH_ACCESS) && i_apb.psel && i_apb.penable;

    // Phase tracking
    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            PH_IDLE: begin
                if (setup) begin
                    phase_d = PH_ACCESS;
                end
            end
            PH_ACCESS: begin
                // Back-to-back setup keeps us in access, otherwise done
                phase_d = setup ? PH_ACCESS : PH_IDLE;
            end
            default: begin
                phase_d = PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            phase_q <= PH_IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    // One request per transfer, issued in the setup cycle.
    // The register file answers at the edge that ends setup, so the
    // response is already there when the access phase starts.
    always_comb begin
        o_req.valid = setup;
        o_req.write = i_apb.pwrite;
        o_req.addr  = i_apb.paddr;
        o_req.wdata = i_apb.pwdata;
        o_req.wstrb = i_apb.pstrb;
    end

    // Response, only visible during access
    always_comb begin
        o_apb.pready  = access;
        o_apb.prdata  = access ? i_resp.rdata : 32'h0;
        o_apb.pslverr = access && i_resp.err;
    end

endmodule

`default_nettype wire

/* rtl/clint_pkg.sv */
// CLINT shared definitions
// APB and internal register bus structs, decode enums and the address map

`default_nettype none

package clint_pkg;

    // Register address width of the APB port
    localparam int CLINT_ADDR_BITS = 16;

    // Address map, usual CLINT layout
    localparam logic [CLINT_ADDR_BITS-1:0] MSIP_BASE     = 16'h0000; // 4 bytes per hart
    localparam logic [CLINT_ADDR_BITS-1:0] MTIMECMP_BASE = 16'h4000; // 8 bytes per hart
    localparam logic [CLINT_ADDR_BITS-1:0] MTIME_ADDR    = 16'hBFF8; // Low word, high at +4

    // APB master to slave
    typedef struct packed {
        logic [CLINT_ADDR_BITS-1:0] paddr;
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [31:0]                pwdata;
        logic [3:0]                 pstrb;
    } apb_req_t;

    // APB slave to master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_resp_t;

    // Internal register request, valid is a single-cycle pulse
    typedef struct packed {
        logic                       valid;
        logic                       write;
        logic [CLINT_ADDR_BITS-1:0] addr;
        logic [31:0]                wdata;
        logic [3:0]                 wstrb;
    } reg_req_t;

    // Internal register response, held until the next request
    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } reg_resp_t;

    // Register class of a decoded address
    typedef enum logic [2:0] {
        REG_MSIP,
        REG_MTIMECMP_LO,
        REG_MTIMECMP_HI,
        REG_MTIME_LO,
        REG_MTIME_HI,
        REG_NONE
    } reg_kind_e;

    // APB bridge phase
    typedef enum logic {
        PH_IDLE,
        PH_ACCESS
    } apb_phase_e;

endpackage

`default_nettype wire
